// File: hdl/loong_isa_pkg.sv
package loong_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] insn_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcode, inst[31:26]
    localparam logic [5:0] OPC_SPECIAL   = 6'h00; // 3r, shifts, imm alu
    localparam logic [5:0] OPC_LU12I     = 6'h05; // inst[25] must be 0
    localparam logic [5:0] OPC_PCADDU12I = 6'h07;
    localparam logic [5:0] OPC_MEM       = 6'h0a;
    localparam logic [5:0] OPC_JIRL      = 6'h13;
    localparam logic [5:0] OPC_B         = 6'h14;
    localparam logic [5:0] OPC_BL        = 6'h15;
    localparam logic [5:0] OPC_BEQ       = 6'h16;
    localparam logic [5:0] OPC_BNE       = 6'h17;
    localparam logic [5:0] OPC_BLT       = 6'h18;
    localparam logic [5:0] OPC_BGE       = 6'h19;
    localparam logic [5:0] OPC_BLTU      = 6'h1a;
    localparam logic [5:0] OPC_BGEU      = 6'h1b;

    // inst[25:22] under OPC_SPECIAL
    localparam logic [3:0] SUB22_REG    = 4'h0;
    localparam logic [3:0] SUB22_SHIFTI = 4'h1;
    localparam logic [3:0] SUB22_SLTI   = 4'h8;
    localparam logic [3:0] SUB22_SLTUI  = 4'h9;
    localparam logic [3:0] SUB22_ADDI   = 4'ha;
    localparam logic [3:0] SUB22_ANDI   = 4'hd;
    localparam logic [3:0] SUB22_ORI    = 4'he;
    localparam logic [3:0] SUB22_XORI   = 4'hf;

    // inst[25:22] under OPC_MEM
    localparam logic [3:0] MEM_LD_B  = 4'h0;
    localparam logic [3:0] MEM_LD_H  = 4'h1;
    localparam logic [3:0] MEM_LD_W  = 4'h2;
    localparam logic [3:0] MEM_ST_B  = 4'h4;
    localparam logic [3:0] MEM_ST_H  = 4'h5;
    localparam logic [3:0] MEM_ST_W  = 4'h6;
    localparam logic [3:0] MEM_LD_BU = 4'h8;
    localparam logic [3:0] MEM_LD_HU = 4'h9;

    // inst[21:20]
    localparam logic [1:0] SUB20_SHIFTI = 2'h0;
    localparam logic [1:0] SUB20_3R     = 2'h1;

    // inst[19:15]
    localparam logic [4:0] FN_ADD  = 5'h00;
    localparam logic [4:0] FN_SLLI = 5'h01;
    localparam logic [4:0] FN_SUB  = 5'h02;
    localparam logic [4:0] FN_SLT  = 5'h04;
    localparam logic [4:0] FN_SLTU = 5'h05;
    localparam logic [4:0] FN_NOR  = 5'h08;
    localparam logic [4:0] FN_AND  = 5'h09;
    localparam logic [4:0] FN_SRLI = 5'h09;
    localparam logic [4:0] FN_OR   = 5'h0a;
    localparam logic [4:0] FN_XOR  = 5'h0b;
    localparam logic [4:0] FN_SLL  = 5'h0e;
    localparam logic [4:0] FN_SRL  = 5'h0f;
    localparam logic [4:0] FN_SRA  = 5'h10;
    localparam logic [4:0] FN_SRAI = 5'h11;

endpackage

// File: hdl/id_ctrl_pkg.sv
package id_ctrl_pkg;

    // one-hot alu operation
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [4:0] load_op_t;

    localparam int LOAD_B  = 0;
    localparam int LOAD_H  = 1;
    localparam int LOAD_W  = 2;
    localparam int LOAD_BU = 3;
    localparam int LOAD_HU = 4;

    typedef logic [2:0] store_op_t;

    localparam int STORE_B = 0;
    localparam int STORE_H = 1;
    localparam int STORE_W = 2;

    // conditional branches sit in the low six bits
    typedef logic [8:0] br_op_t;

    localparam int BR_BEQ  = 0;
    localparam int BR_BNE  = 1;
    localparam int BR_BLT  = 2;
    localparam int BR_BGE  = 3;
    localparam int BR_BLTU = 4;
    localparam int BR_BGEU = 5;
    localparam int BR_JIRL = 6;
    localparam int BR_B    = 7;
    localparam int BR_BL   = 8;

endpackage

// File: hdl/inst_decoder.sv
module inst_decoder
    import loong_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  insn_t     inst,
    output alu_op_t   alu_op,
    output load_op_t  load_op,
    output store_op_t store_op,
    output br_op_t    br_op,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output reg_addr_t dest,
    output word_t     imm,
    output word_t     br_offs,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      use_rj,
    output logic      use_rkd,
    output logic      gr_we
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    reg_addr_t   rd, rj, rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    logic is_3r, is_shifti, is_spec, is_mem;
    logic inst_slli, inst_srli, inst_srai;
    logic inst_addi, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i, inst_pcaddu12i;
    logic is_load, is_store, is_cond_br;
    logic need_si12, need_si20, src2_is_4;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]}; // offs[25:16] lives in the low bits

    assign is_spec   = (op_31_26 == OPC_SPECIAL);
    assign is_3r     = is_spec && op_25_22 == SUB22_REG && op_21_20 == SUB20_3R;
    assign is_shifti = is_spec && op_25_22 == SUB22_SHIFTI && op_21_20 == SUB20_SHIFTI;
    assign is_mem    = (op_31_26 == OPC_MEM);

    assign inst_slli  = is_shifti && op_19_15 == FN_SLLI;
    assign inst_srli  = is_shifti && op_19_15 == FN_SRLI;
    assign inst_srai  = is_shifti && op_19_15 == FN_SRAI;
    assign inst_addi  = is_spec && op_25_22 == SUB22_ADDI;
    assign inst_slti  = is_spec && op_25_22 == SUB22_SLTI;
    assign inst_sltui = is_spec && op_25_22 == SUB22_SLTUI;
    assign inst_andi  = is_spec && op_25_22 == SUB22_ANDI;
    assign inst_ori   = is_spec && op_25_22 == SUB22_ORI;
    assign inst_xori  = is_spec && op_25_22 == SUB22_XORI;

    assign inst_lu12i     = op_31_26 == OPC_LU12I && !inst[25];
    assign inst_pcaddu12i = op_31_26 == OPC_PCADDU12I && !inst[25];

    assign load_op[LOAD_B]    = is_mem && op_25_22 == MEM_LD_B;
    assign load_op[LOAD_H]    = is_mem && op_25_22 == MEM_LD_H;
    assign load_op[LOAD_W]    = is_mem && op_25_22 == MEM_LD_W;
    assign load_op[LOAD_BU]   = is_mem && op_25_22 == MEM_LD_BU;
    assign load_op[LOAD_HU]   = is_mem && op_25_22 == MEM_LD_HU;
    assign store_op[STORE_B]  = is_mem && op_25_22 == MEM_ST_B;
    assign store_op[STORE_H]  = is_mem && op_25_22 == MEM_ST_H;
    assign store_op[STORE_W]  = is_mem && op_25_22 == MEM_ST_W;

    assign br_op[BR_BEQ]  = (op_31_26 == OPC_BEQ);
    assign br_op[BR_BNE]  = (op_31_26 == OPC_BNE);
    assign br_op[BR_BLT]  = (op_31_26 == OPC_BLT);
    assign br_op[BR_BGE]  = (op_31_26 == OPC_BGE);
    assign br_op[BR_BLTU] = (op_31_26 == OPC_BLTU);
    assign br_op[BR_BGEU] = (op_31_26 == OPC_BGEU);
    assign br_op[BR_JIRL] = (op_31_26 == OPC_JIRL);
    assign br_op[BR_B]    = (op_31_26 == OPC_B);
    assign br_op[BR_BL]   = (op_31_26 == OPC_BL);

    assign is_load    = |load_op;
    assign is_store   = |store_op;
    assign is_cond_br = |br_op[BR_BGEU:BR_BEQ];

    // address calc and link value go through the adder as well
    assign alu_op[ALU_ADD]  = (is_3r && op_19_15 == FN_ADD) || inst_addi || is_load || is_store
                            || br_op[BR_JIRL] || br_op[BR_BL] || inst_pcaddu12i;
    assign alu_op[ALU_SUB]  = is_3r && op_19_15 == FN_SUB;
    assign alu_op[ALU_SLT]  = (is_3r && op_19_15 == FN_SLT) || inst_slti;
    assign alu_op[ALU_SLTU] = (is_3r && op_19_15 == FN_SLTU) || inst_sltui;
    assign alu_op[ALU_AND]  = (is_3r && op_19_15 == FN_AND) || inst_andi;
    assign alu_op[ALU_NOR]  = is_3r && op_19_15 == FN_NOR;
    assign alu_op[ALU_OR]   = (is_3r && op_19_15 == FN_OR) || inst_ori;
    assign alu_op[ALU_XOR]  = (is_3r && op_19_15 == FN_XOR) || inst_xori;
    assign alu_op[ALU_SLL]  = (is_3r && op_19_15 == FN_SLL) || inst_slli;
    assign alu_op[ALU_SRL]  = (is_3r && op_19_15 == FN_SRL) || inst_srli;
    assign alu_op[ALU_SRA]  = (is_3r && op_19_15 == FN_SRA) || inst_srai;
    assign alu_op[ALU_LUI]  = inst_lu12i;

    assign need_si12 = inst_addi || inst_slti || inst_sltui || is_load || is_store
                     || inst_slli || inst_srli || inst_srai; // ui5 sits in the low bits
    assign need_si20 = inst_lu12i || inst_pcaddu12i;
    assign src2_is_4 = br_op[BR_JIRL] || br_op[BR_BL];

    assign imm = src2_is_4 ? word_t'(32'd4)
               : need_si20 ? {i20, 12'b0}
               : need_si12 ? {{20{i12[11]}}, i12}
               : {20'b0, i12};

    assign br_offs = (br_op[BR_B] || br_op[BR_BL]) ? {{4{i26[25]}}, i26, 2'b0}
                                                   : {{14{i16[15]}}, i16, 2'b0};

    assign src1_is_pc  = br_op[BR_JIRL] || br_op[BR_BL] || inst_pcaddu12i;
    assign src2_is_imm = need_si12 || need_si20 || src2_is_4 || inst_andi || inst_ori
                       || inst_xori;

    assign raddr1 = rj;
    assign raddr2 = (is_cond_br || is_store) ? rd : rk;
    assign dest   = br_op[BR_BL] ? reg_addr_t'(5'd1) : rd;
    assign gr_we  = (|alu_op) && !is_store;

    // jirl reads rj for its target even though src1 is the pc
    assign use_rj  = (!src1_is_pc && !inst_lu12i && (|alu_op)) || is_cond_br || br_op[BR_JIRL];
    assign use_rkd = (!src2_is_imm && (|alu_op)) || is_cond_br || is_store;

    always_comb begin
        assert final ($onehot0(alu_op)) else $error("alu_op not one-hot: %b", alu_op);
    end

endmodule

// File: hdl/reg_file.sv
module reg_file
    import loong_isa_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, same-cycle write is covered by the bypass
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/operand_bypass.sv
module operand_bypass
    import loong_isa_pkg::*;
(
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  word_t     rdata1,
    input  word_t     rdata2,
    input  logic      use_rj,
    input  logic      use_rkd,
    input  logic      exe_we,
    input  logic      exe_is_load,
    input  reg_addr_t exe_dest,
    input  word_t     exe_result,
    input  logic      mem_we,
    input  logic      mem_is_load,
    input  reg_addr_t mem_dest,
    input  word_t     mem_result,
    input  logic      wb_we,
    input  reg_addr_t wb_dest,
    input  word_t     wb_data,
    output word_t     rj_value,
    output word_t     rkd_value,
    output logic      load_hazard
);

    logic exe_hit1, exe_hit2, mem_hit1, mem_hit2, wb_hit1, wb_hit2;

    function automatic logic hit(input logic we, input reg_addr_t dst, input reg_addr_t src);
        return we && dst == src && src != '0;
    endfunction

    assign exe_hit1 = hit(exe_we, exe_dest, raddr1);
    assign exe_hit2 = hit(exe_we, exe_dest, raddr2);
    assign mem_hit1 = hit(mem_we, mem_dest, raddr1);
    assign mem_hit2 = hit(mem_we, mem_dest, raddr2);
    assign wb_hit1  = hit(wb_we, wb_dest, raddr1);
    assign wb_hit2  = hit(wb_we, wb_dest, raddr2);

    // youngest producer first
    assign rj_value = exe_hit1 ? exe_result
                    : mem_hit1 ? mem_result
                    : wb_hit1  ? wb_data
                    : rdata1;

    assign rkd_value = exe_hit2 ? exe_result
                     : mem_hit2 ? mem_result
                     : wb_hit2  ? wb_data
                     : rdata2;

    // load data not there yet, wait for it
    assign load_hazard = (exe_is_load && ((use_rj && exe_hit1) || (use_rkd && exe_hit2)))
                       || (mem_is_load && ((use_rj && mem_hit1) || (use_rkd && mem_hit2)));

endmodule

// File: hdl/branch_unit.sv
module branch_unit
    import loong_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  br_op_t br_op,
    input  word_t  pc,
    input  word_t  br_offs,
    input  word_t  rj_value,
    input  word_t  rkd_value,
    input  logic   fire,
    output logic   br_taken,
    output word_t  br_target
);

    word_t diff;
    logic  carry;
    logic  eq, lt, ltu;
    logic  cond;

    // rj - rkd as rj + ~rkd + 1, carry out means no borrow
    assign {carry, diff} = {1'b0, rj_value} + {1'b0, ~rkd_value} + 33'd1;

    assign eq  = (diff == '0);
    assign ltu = ~carry;
    assign lt  = (rj_value[31] & ~rkd_value[31])
               | (~(rj_value[31] ^ rkd_value[31]) & diff[31]);

    assign cond = (br_op[BR_BEQ]  &  eq)
                | (br_op[BR_BNE]  & ~eq)
                | (br_op[BR_BLT]  &  lt)
                | (br_op[BR_BGE]  & ~lt)
                | (br_op[BR_BLTU] &  ltu)
                | (br_op[BR_BGEU] & ~ltu)
                | br_op[BR_JIRL] | br_op[BR_B] | br_op[BR_BL]; // unconditional

    assign br_taken = cond && fire;

    // for jirl br_offs already holds sext(si16) << 2
    assign br_target = br_op[BR_JIRL] ? rj_value + br_offs : pc + br_offs;

endmodule

// File: hdl/id_stage.sv
module id_stage
    import loong_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fs2ds_valid,
    input  word_t     fs_pc,
    input  insn_t     fs_inst,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds2es_valid,
    output word_t     ds_pc,
    output alu_op_t   alu_op,
    output word_t     alu_src1,
    output word_t     alu_src2,
    output word_t     rkd_value,
    output load_op_t  load_op,
    output store_op_t store_op,
    output logic      gr_we,
    output reg_addr_t dest,
    input  logic      exe_we,
    input  logic      exe_is_load,
    input  reg_addr_t exe_dest,
    input  word_t     exe_result,
    input  logic      mem_we,
    input  logic      mem_is_load,
    input  reg_addr_t mem_dest,
    input  word_t     mem_result,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    output logic      br_taken,
    output word_t     br_target
);

    logic      ds_valid;
    insn_t     ds_inst;
    logic      ready_go;
    logic      load_hazard;
    br_op_t    br_op;
    reg_addr_t raddr1, raddr2;
    word_t     rdata1, rdata2;
    word_t     rj_value;
    word_t     imm, br_offs;
    logic      src1_is_pc, src2_is_imm;
    logic      use_rj, use_rkd;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs2ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs2ds_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    assign ready_go    = ~load_hazard;
    assign ds_allowin  = ~ds_valid || (ready_go && es_allowin);
    assign ds2es_valid = ds_valid && ready_go;

    inst_decoder u_dec (
        .inst        (ds_inst),
        .alu_op      (alu_op),
        .load_op     (load_op),
        .store_op    (store_op),
        .br_op       (br_op),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .dest        (dest),
        .imm         (imm),
        .br_offs     (br_offs),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .use_rj      (use_rj),
        .use_rkd     (use_rkd),
        .gr_we       (gr_we)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .raddr2 (raddr2),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    operand_bypass u_byp (
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .use_rj      (use_rj),
        .use_rkd     (use_rkd),
        .exe_we      (exe_we),
        .exe_is_load (exe_is_load),
        .exe_dest    (exe_dest),
        .exe_result  (exe_result),
        .mem_we      (mem_we),
        .mem_is_load (mem_is_load),
        .mem_dest    (mem_dest),
        .mem_result  (mem_result),
        .wb_we       (rf_we),
        .wb_dest     (rf_waddr),
        .wb_data     (rf_wdata),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .load_hazard (load_hazard)
    );

    branch_unit u_br (
        .br_op     (br_op),
        .pc        (ds_pc),
        .br_offs   (br_offs),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .fire      (ds2es_valid), // valid and ready_go
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    assign alu_src1 = src1_is_pc ? ds_pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    assert property (@(posedge clk) disable iff (rst) br_taken |-> ds_valid);

    // held instruction must not move while EXE refuses it
    assert property (@(posedge clk) disable iff (rst)
        ds_valid && !es_allowin |=> $stable(ds_pc) && $stable(ds_inst));

endmodule

// File: sim/id_stage_tb.sv
module id_stage_tb
    import loong_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int CYCLE_LIMIT = 400; // directed run needs about 170 cycles

    logic      clk, rst;
    logic      fs2ds_valid;
    word_t     fs_pc;
    insn_t     fs_inst;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds2es_valid;
    word_t     ds_pc;
    alu_op_t   alu_op;
    word_t     alu_src1, alu_src2, rkd_value;
    load_op_t  load_op;
    store_op_t store_op;
    logic      gr_we;
    reg_addr_t dest;
    logic      exe_we, exe_is_load;
    reg_addr_t exe_dest;
    word_t     exe_result;
    logic      mem_we, mem_is_load;
    reg_addr_t mem_dest;
    word_t     mem_result;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    logic      br_taken;
    word_t     br_target;

    word_t rng_state = 32'hd242_f4cf;

    id_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Finished with errors");
        $fatal(1);
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_load_op(input string name, input load_op_t exp, input load_op_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_store_op(input string name, input store_op_t exp,
                                  input store_op_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic alu_op_t alu_bit(input int idx);
        alu_op_t v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    function automatic insn_t r3_insn(input logic [4:0] fn, input reg_addr_t rk, rj, rd);
        return {OPC_SPECIAL, SUB22_REG, SUB20_3R, fn, rk, rj, rd};
    endfunction

    function automatic insn_t imm_insn(input logic [5:0] opc, input logic [3:0] sub,
                                       input logic [11:0] i12, input reg_addr_t rj, rd);
        return {opc, sub, i12, rj, rd};
    endfunction

    function automatic insn_t br_insn(input logic [5:0] opc, input logic [15:0] off,
                                      input reg_addr_t rj, rd);
        return {opc, off, rj, rd};
    endfunction

    function automatic insn_t jump_insn(input logic [5:0] opc, input logic [25:0] off);
        return {opc, off[15:0], off[25:16]}; // high offset bits go in the low field
    endfunction

    // offsets count words, signed
    function automatic word_t offs16_word(input logic [15:0] off);
        int v;
        v = $signed(off);
        return v * 4;
    endfunction

    function automatic word_t offs26_word(input logic [25:0] off);
        int v;
        v = $signed(off);
        return v * 4;
    endfunction

    function automatic logic [5:0] br_opcode(input int kind);
        case (kind)
            0: return OPC_BEQ;
            1: return OPC_BNE;
            2: return OPC_BLT;
            3: return OPC_BGE;
            4: return OPC_BLTU;
            default: return OPC_BGEU;
        endcase
    endfunction

    function automatic logic br_expect(input int kind, input word_t a, input word_t b);
        case (kind)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) < $signed(b);
            3: return $signed(a) >= $signed(b);
            4: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic settle();
        #1;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        rf_we    = 1'b1;
        rf_waddr = addr;
        rf_wdata = data;
        step();
        rf_we    = 1'b0;
    endtask

    task automatic clear_fwd();
        exe_we      = 1'b0;
        exe_is_load = 1'b0;
        exe_dest    = '0;
        exe_result  = '0;
        mem_we      = 1'b0;
        mem_is_load = 1'b0;
        mem_dest    = '0;
        mem_result  = '0;
        rf_we       = 1'b0;
        rf_waddr    = '0;
        rf_wdata    = '0;
    endtask

    // offer one instruction, wait for allowin, return after the capture edge
    task automatic load_insn(input word_t pc, input insn_t inst);
        fs2ds_valid = 1'b1;
        fs_pc       = pc;
        fs_inst     = inst;
        settle();
        while (!ds_allowin) begin
            step();
            settle();
        end
        step();
        fs2ds_valid = 1'b0;
    endtask

    task automatic reset_state();
        check_bit("reset ds2es_valid", 1'b0, ds2es_valid);
        check_bit("reset br_taken", 1'b0, br_taken);
        check_bit("reset ds_allowin", 1'b1, ds_allowin);
    endtask

    task automatic alu_decode();
        word_t a, b, pc;
        a = next_rand();
        b = next_rand();
        write_reg(5'd4, a);
        write_reg(5'd5, b);
        load_insn(32'h1c00_0000, r3_insn(FN_ADD, 5'd5, 5'd4, 5'd6));
        settle();
        check_alu_op("add.w alu_op", alu_bit(ALU_ADD), alu_op);
        check_word("add.w src1", a, alu_src1);
        check_word("add.w src2", b, alu_src2);
        check_word("add.w rkd", b, rkd_value);
        check_addr("add.w dest", 5'd6, dest);
        check_bit("add.w gr_we", 1'b1, gr_we);
        check_bit("add.w valid", 1'b1, ds2es_valid);
        step();
        load_insn(32'h1c00_0004, imm_insn(OPC_SPECIAL, SUB22_ANDI, 12'h9a5, 5'd4, 5'd7));
        settle();
        check_alu_op("andi alu_op", alu_bit(ALU_AND), alu_op);
        check_word("andi src2", 32'h0000_09a5, alu_src2);
        step();
        load_insn(32'h1c00_0008, imm_insn(OPC_SPECIAL, SUB22_ADDI, 12'hf38, 5'd4, 5'd7));
        settle();
        check_word("addi.w src1", a, alu_src1);
        check_word("addi.w src2", 32'hffff_ff38, alu_src2);
        step();
        load_insn(32'h1c00_000c, {OPC_LU12I, 1'b0, 20'h12345, 5'd8});
        settle();
        check_alu_op("lu12i.w alu_op", alu_bit(ALU_LUI), alu_op);
        check_word("lu12i.w src2", 32'h1234_5000, alu_src2);
        step();
        load_insn(32'h1c00_0010, imm_insn(OPC_MEM, MEM_LD_H, 12'h010, 5'd4, 5'd9));
        settle();
        check_load_op("ld.h load_op", load_op_t'(1) << LOAD_H, load_op);
        check_store_op("ld.h store_op", '0, store_op);
        check_bit("ld.h gr_we", 1'b1, gr_we);
        check_word("ld.h src2", 32'h0000_0010, alu_src2);
        step();
        pc = 32'h1c00_0100;
        load_insn(pc, jump_insn(OPC_BL, 26'h3ff_fff0));
        settle();
        check_word("bl src1", pc, alu_src1);
        check_word("bl src2", 32'd4, alu_src2);
        check_addr("bl dest", 5'd1, dest);
        check_bit("bl taken", 1'b1, br_taken);
        check_word("bl target", pc + offs26_word(26'h3ff_fff0), br_target);
        step();
    endtask

    task automatic forwarding_priority();
        word_t e, m, w;
        e = next_rand();
        m = next_rand();
        w = next_rand();
        write_reg(5'd9, next_rand());
        load_insn(32'h1c00_0200, r3_insn(FN_ADD, 5'd0, 5'd9, 5'd10));
        es_allowin = 1'b0; // hold it in the stage
        exe_we     = 1'b1;
        exe_dest   = 5'd9;
        exe_result = e;
        mem_we     = 1'b1;
        mem_dest   = 5'd9;
        mem_result = m;
        rf_we      = 1'b1;
        rf_waddr   = 5'd9;
        rf_wdata   = ~w;
        settle();
        check_word("fwd exe wins", e, alu_src1);
        step();
        exe_we = 1'b0;
        settle();
        check_word("fwd mem wins", m, alu_src1);
        step();
        mem_we   = 1'b0;
        rf_wdata = w; // r9 still holds the older write
        settle();
        check_word("fwd wb wins", w, alu_src1);
        step();
        rf_we = 1'b0;
        settle();
        check_word("rf holds wb write", w, alu_src1);
        es_allowin = 1'b1;
        step();
        load_insn(32'h1c00_0204, r3_insn(FN_ADD, 5'd0, 5'd0, 5'd10));
        exe_we     = 1'b1;
        exe_dest   = 5'd0;
        exe_result = e;
        settle();
        check_word("r0 reads zero", 32'd0, alu_src1);
        clear_fwd();
        step();
    endtask

    task automatic load_use_interlock();
        word_t x, y;
        x = next_rand();
        y = next_rand();
        write_reg(5'd11, x);
        load_insn(32'h1c00_0300, r3_insn(FN_ADD, 5'd0, 5'd11, 5'd12));
        exe_we      = 1'b1;
        exe_is_load = 1'b1;
        exe_dest    = 5'd11;
        exe_result  = y;
        settle();
        check_bit("load-use valid", 1'b0, ds2es_valid);
        check_bit("load-use allowin", 1'b0, ds_allowin);
        step();
        settle();
        check_bit("load-use still stalled", 1'b0, ds2es_valid);
        step();
        exe_is_load = 1'b0; // load data now forwarded
        settle();
        check_bit("load-use release", 1'b1, ds2es_valid);
        check_word("load-use data", y, alu_src1);
        clear_fwd();
        step();
        load_insn(32'h1c00_0304, imm_insn(OPC_MEM, MEM_ST_W, 12'h008, 5'd0, 5'd13));
        mem_we      = 1'b1;
        mem_is_load = 1'b1;
        mem_dest    = 5'd13;
        mem_result  = y;
        settle();
        check_bit("store data stall", 1'b0, ds2es_valid);
        step();
        mem_is_load = 1'b0;
        settle();
        check_bit("store data release", 1'b1, ds2es_valid);
        check_store_op("st.w store_op", store_op_t'(1) << STORE_W, store_op);
        check_load_op("st.w load_op", '0, load_op);
        check_bit("st.w gr_we", 1'b0, gr_we);
        check_word("store data fwd", y, rkd_value);
        clear_fwd();
        step();
        // rk field of addi is immediate bits, not a source
        load_insn(32'h1c00_0308, imm_insn(OPC_SPECIAL, SUB22_ADDI, {7'd0, 5'd14}, 5'd11, 5'd12));
        exe_we      = 1'b1;
        exe_is_load = 1'b1;
        exe_dest    = 5'd14;
        settle();
        check_bit("no stall on unused reg", 1'b1, ds2es_valid);
        clear_fwd();
        step();
    endtask

    task automatic branch_resolution();
        word_t a, b, pc;
        logic [15:0] off;
        for (int i = 0; i < 8; i++) begin
            a = next_rand();
            b = next_rand();
            if (i % 3 == 0) begin
                b = a;
            end
            write_reg(5'd15, a);
            write_reg(5'd16, b);
            for (int k = 0; k < 6; k++) begin
                pc  = next_rand() & 32'hffff_fffc;
                off = 16'(next_rand());
                load_insn(pc, br_insn(br_opcode(k), off, 5'd15, 5'd16));
                settle();
                check_bit($sformatf("branch kind %0d taken", k), br_expect(k, a, b), br_taken);
                check_word($sformatf("branch kind %0d target", k), pc + offs16_word(off),
                           br_target);
                step();
            end
        end
        a = next_rand();
        write_reg(5'd17, a);
        load_insn(32'h1c00_0400, br_insn(OPC_JIRL, 16'hfffe, 5'd17, 5'd0));
        settle();
        check_bit("jirl taken", 1'b1, br_taken);
        check_word("jirl target", a + offs16_word(16'hfffe), br_target);
        step();
        pc = 32'h1c00_0500;
        load_insn(pc, jump_insn(OPC_B, 26'h000_1234));
        settle();
        check_bit("b taken", 1'b1, br_taken);
        check_word("b target", pc + offs26_word(26'h000_1234), br_target);
        step();
    endtask

    task automatic back_pressure();
        word_t p1, p2;
        p1 = 32'h1c00_0800;
        p2 = 32'h1c00_0804;
        load_insn(p1, r3_insn(FN_ADD, 5'd0, 5'd0, 5'd3));
        es_allowin  = 1'b0;
        fs2ds_valid = 1'b1;
        fs_pc       = p2;
        fs_inst     = imm_insn(OPC_SPECIAL, SUB22_ORI, 12'h055, 5'd0, 5'd3);
        for (int i = 0; i < 3; i++) begin
            settle();
            check_bit("backpressure valid", 1'b1, ds2es_valid);
            check_bit("backpressure allowin", 1'b0, ds_allowin);
            check_word("backpressure pc", p1, ds_pc);
            step();
        end
        es_allowin = 1'b1;
        settle();
        check_bit("release allowin", 1'b1, ds_allowin);
        step();
        fs2ds_valid = 1'b0;
        settle();
        check_word("next insn pc", p2, ds_pc);
        check_word("next insn src2", 32'h0000_0055, alu_src2);
        step();
    endtask

    initial begin
        rst         = 1'b1;
        es_allowin  = 1'b1;
        fs_pc       = '0;
        clear_fwd();
        // a clean word lands in the stage register, ds_valid is held clear by rst
        fs2ds_valid = 1'b1;
        fs_inst     = r3_insn(FN_ADD, 5'd0, 5'd0, 5'd0);
        repeat (3) step();
        rst         = 1'b0;
        fs2ds_valid = 1'b0;
        settle();
        reset_state();
        step();
        alu_decode();
        forwarding_priority();
        load_use_interlock();
        branch_resolution();
        back_pressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: verilog.f
hdl/loong_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/id_stage.sv
sim/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - hdl/loong_isa_pkg.sv
  - hdl/id_ctrl_pkg.sv
  - hdl/inst_decoder.sv
  - hdl/reg_file.sv
  - hdl/operand_bypass.sv
  - hdl/branch_unit.sv
  - hdl/id_stage.sv
  - target: test
    files:
      - sim/id_stage_tb.sv
